/* dsp_buffer_top.f */
src/dsp_pkg.sv
src/setting_reg.sv
src/pkt_buffer_ram.sv
src/pkt_buffer_ctrl.sv
src/dspengine_8to16.sv
src/dsp_buffer_top.sv
bench/dsp_buffer_tb.sv

/* bench/dsp_buffer_tb.sv */
module dsp_buffer_tb;

   localparam int DRIVE_DLY = 2;
   // 40 packets, each at most 3*64 engine cycles plus 2*130 load and unload cycles
   localparam int TIMEOUT_CYCLES = 20000;

   logic        clk;
   logic        rst_i;
   logic        clear_i;
   logic        set_stb_i;
   logic [7:0]  set_addr_i;
   logic [31:0] set_data_i;
   logic        in_stb_i;
   logic [35:0] in_data_i;
   logic        busy_o;
   logic        out_stb_o;
   logic [35:0] out_data_o;

   logic [31:0] rng_state;
   logic [35:0] pkt_q[$];
   logic [35:0] exp_q[$];
   logic [35:0] exp_w;
   logic        conv_mode;
   string       test_name;
   int          out_idx;
   int          mismatch_cnt;
   int          other_err_cnt;
   int          cycle_cnt;
   int          i;

   dsp_buffer_top dut (
      .clk(clk), .rst_i(rst_i), .clear_i(clear_i),
      .set_stb_i(set_stb_i), .set_addr_i(set_addr_i), .set_data_i(set_data_i),
      .in_stb_i(in_stb_i), .in_data_i(in_data_i),
      .busy_o(busy_o), .out_stb_o(out_stb_o), .out_data_o(out_data_o));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [7:0] other_address();
      logic [31:0] r;
      logic [7:0]  a;
      r = rand32();
      a = r[7:0];
      if (a == dsp_pkg::CONV_ADDR)
         a = a ^ 8'h01;
      return a;
   endfunction

   task automatic step();
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   // random packet into pkt_q, reference output into exp_q
   // kind 0: IF data with trailer, kind 1: not IF or no trailer, else anything
   task automatic build_packet(input int kind, input int odd_sel);
      dsp_pkg::buf_word_u hdr;
      dsp_pkg::buf_word_u hdr_out;
      dsp_pkg::buf_word_u s;
      logic [31:0]        r;
      logic [31:0]        trl;
      int                 n;
      int                 hdr_words;
      int                 k;
      bit                 odd;
      bit                 conv;
      pkt_q.delete();
      exp_q.delete();
      out_idx = 0;
      n = 1 + (rand32() % 60);
      r = rand32();
      hdr = rand32();
      if (kind == 0)
      begin
         hdr.hdr.pkt_type = 3'd0;
         hdr.hdr.has_trl  = 1'b1;
      end
      else if (kind == 1)
      begin
         hdr.hdr.pkt_type = r[0] ? 3'(1 + (r[3:1] % 7)) : 3'd0;
         hdr.hdr.has_trl  = r[0] ? r[4] : 1'b0;
      end
      else
      begin
         hdr.hdr.pkt_type = r[5] ? 3'd0 : r[8:6];
         hdr.hdr.has_trl  = r[9] | r[10];
      end
      hdr_words = 1;
      if (hdr.hdr.has_sid)
         hdr_words = hdr_words + 1;
      if (hdr.hdr.has_cid)
         hdr_words = hdr_words + 2;
      if (hdr.hdr.tsi != 2'd0)
         hdr_words = hdr_words + 1;
      if (hdr.hdr.tsf != 2'd0)
         hdr_words = hdr_words + 2;
      trl = rand32();
      if (odd_sel == 0)
         trl[8] = 1'b0;
      else if (odd_sel == 1)
         trl = trl | 32'h0010_0100;
      // transport header, VITA header, options, payload, trailer
      pkt_q.push_back({4'b0001, rand32()});
      pkt_q.push_back({4'b0000, hdr});
      for (k = 0; k < hdr_words - 1 + n; k++)
         pkt_q.push_back({4'b0000, rand32()});
      pkt_q.push_back({4'b0010, trl});
      conv = conv_mode && (hdr.hdr.pkt_type == 3'd0) && hdr.hdr.has_trl;
      odd = trl[20] & trl[8];
      hdr_out = hdr;
      if (!conv)
      begin
         hdr_out.hdr.length = 16'(pkt_q.size() - 1);
         for (k = 0; k < pkt_q.size(); k++)
            exp_q.push_back((k == 1) ? {4'b0000, hdr_out} : pkt_q[k]);
      end
      else
      begin
         // new word count minus one, that is the new trailer address
         hdr_out.hdr.length = 16'(hdr_words + 2 * n - int'(odd) + 1);
         exp_q.push_back(pkt_q[0]);
         exp_q.push_back({4'b0000, hdr_out});
         for (k = 2; k <= hdr_words; k++)
            exp_q.push_back(pkt_q[k]);
         for (k = 0; k < n; k++)
         begin
            s = pkt_q[1 + hdr_words + k][31:0];
            exp_q.push_back({4'b0000, s.smp.i0, 8'h00, s.smp.q0, 8'h00});
            if (!(odd && (k == n - 1)))
               exp_q.push_back({4'b0000, s.smp.i1, 8'h00, s.smp.q1, 8'h00});
         end
         exp_q.push_back({4'b0010, trl});
      end
   endtask

   task automatic load_packet();
      int k;
      for (k = 0; k < pkt_q.size(); k++)
      begin
         step();
         in_stb_i  = 1'b1;
         in_data_i = pkt_q[k];
      end
      step();
      in_stb_i  = 1'b0;
      in_data_i = '0;
   endtask

   // all expected words seen and the buffer back in load
   task automatic wait_drained();
      @(negedge clk);
      while ((exp_q.size() != 0) || busy_o)
         @(negedge clk);
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      step();
      set_stb_i  = 1'b1;
      set_addr_i = addr;
      set_data_i = data;
      step();
      set_stb_i = 1'b0;
      if (addr == dsp_pkg::CONV_ADDR)
         conv_mode = data[0];
   endtask

   task automatic pulse_clear();
      step();
      clear_i = 1'b1;
      step();
      clear_i = 1'b0;
   endtask

   task automatic check_idle(input string name);
      test_name = name;
      @(negedge clk);
      if (busy_o !== 1'b0)
      begin
         mismatch_cnt++;
         $display("MISMATCH %s busy_o: expected 0, actual %b", name, busy_o);
      end
      if (out_stb_o !== 1'b0)
      begin
         mismatch_cnt++;
         $display("MISMATCH %s out_stb_o: expected 0, actual %b", name, out_stb_o);
      end
   endtask

   task automatic run_packets(input string name, input int count, input int kind,
                              input int odd_sel);
      int p;
      test_name = name;
      for (p = 0; p < count; p++)
      begin
         build_packet(kind, odd_sel);
         load_packet();
         wait_drained();
      end
   endtask

   // output words are stable in the middle of the cycle
   always @(negedge clk)
   begin
      if (!rst_i && out_stb_o)
      begin
         if (exp_q.size() == 0)
         begin
            other_err_cnt++;
            $display("ERROR %s: extra output word %h after the end of the packet",
                     test_name, out_data_o);
         end
         else
         begin
            exp_w = exp_q.pop_front();
            if (out_data_o !== exp_w)
            begin
               mismatch_cnt++;
               $display("MISMATCH %s word %0d: expected %h, actual %h",
                        test_name, out_idx, exp_w, out_data_o);
            end
            if (out_data_o[dsp_pkg::FLAG_EOF] && (exp_q.size() != 0))
            begin
               other_err_cnt++;
               $display("ERROR %s: EOF flag came %0d words early", test_name, exp_q.size());
               exp_q.delete();
            end
            else if ((exp_q.size() == 0) && !out_data_o[dsp_pkg::FLAG_EOF])
            begin
               other_err_cnt++;
               $display("ERROR %s: last word of the packet came without EOF flag",
                        test_name);
            end
         end
         out_idx++;
      end
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt = cycle_cnt + 1;
      end
      $display("run stopped after %0d cycles, the DUT did not finish", cycle_cnt);
      $display("checks stopped: %0d mismatches, %0d other errors",
               mismatch_cnt, other_err_cnt);
      $display(">>> FAIL");
      $finish;
   end

   initial
   begin
      rst_i         = 1'b1;
      clear_i       = 1'b0;
      set_stb_i     = 1'b0;
      set_addr_i    = '0;
      set_data_i    = '0;
      in_stb_i      = 1'b0;
      in_data_i     = '0;
      rng_state     = 32'hdb68;
      conv_mode     = 1'b0;
      mismatch_cnt  = 0;
      other_err_cnt = 0;
      out_idx       = 0;
      test_name     = "reset";
      repeat (4) @(posedge clk);
      #DRIVE_DLY;
      rst_i = 1'b0;
      check_idle("reset");

      write_setting(dsp_pkg::CONV_ADDR, 32'd1);
      run_packets("conv_even", 8, 0, 0);
      run_packets("conv_odd", 6, 0, 1);

      write_setting(dsp_pkg::CONV_ADDR, 32'd0);
      run_packets("pass_disabled", 6, 2, 2);

      write_setting(dsp_pkg::CONV_ADDR, 32'd1);
      run_packets("pass_not_if_or_no_trailer", 8, 1, 2);

      // writes elsewhere must not move the enable
      write_setting(other_address(), 32'd0);
      run_packets("other_addr_keep_on", 2, 0, 2);
      write_setting(dsp_pkg::CONV_ADDR, 32'd0);
      write_setting(other_address(), 32'hffff_ffff);
      run_packets("other_addr_keep_off", 2, 0, 2);

      write_setting(dsp_pkg::CONV_ADDR, 32'd1);
      pulse_clear();
      check_idle("clear_idle");
      build_packet(0, 2);
      load_packet();
      exp_q.delete();
      pulse_clear();
      check_idle("clear_busy");
      run_packets("after_clear", 2, 0, 2);

      for (i = 0; i < 5; i++)
      begin
         write_setting(dsp_pkg::CONV_ADDR, {31'd0, rng_state[3]});
         run_packets("random_mix", 1, 2, 2);
      end

      $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
      if ((mismatch_cnt == 0) && (other_err_cnt == 0))
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

/* src/dsp_buffer_top.sv */
module dsp_buffer_top
(
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       clear_i,
   input  logic                       set_stb_i,
   input  logic [7:0]                 set_addr_i,
   input  logic [31:0]                set_data_i,
   input  logic                       in_stb_i,
   input  logic [dsp_pkg::WORD_W-1:0] in_data_i,
   output logic                       busy_o,
   output logic                       out_stb_o,
   output logic [dsp_pkg::WORD_W-1:0] out_data_o
);

   logic                       convert;
   logic                       access_ok;
   logic                       access_done;
   logic [dsp_pkg::BUF_AW-1:0] access_len;
   logic                       eng_we;
   logic [dsp_pkg::BUF_AW-1:0] eng_adr;
   logic [dsp_pkg::WORD_W-1:0] eng_dat;
   logic                       ram_we;
   logic [dsp_pkg::BUF_AW-1:0] ram_adr;
   logic [dsp_pkg::WORD_W-1:0] ram_wdat;
   logic [dsp_pkg::WORD_W-1:0] ram_rdat;

   // 8-to-16 enable
   setting_reg #(.ADDR(dsp_pkg::CONV_ADDR), .WIDTH(1)) u_conv_reg (
      .clk(clk), .rst_i(rst_i), .strobe_i(set_stb_i), .addr_i(set_addr_i),
      .data_i(set_data_i), .out_o(convert));

   pkt_buffer_ram u_ram (
      .clk(clk), .we_i(ram_we), .adr_i(ram_adr), .dat_i(ram_wdat), .dat_o(ram_rdat));

   pkt_buffer_ctrl u_ctrl (
      .clk(clk), .rst_i(rst_i), .clear_i(clear_i),
      .in_stb_i(in_stb_i), .in_data_i(in_data_i),
      .eng_we_i(eng_we), .eng_adr_i(eng_adr), .eng_dat_i(eng_dat),
      .access_done_i(access_done), .access_ok_o(access_ok), .access_len_o(access_len),
      .ram_we_o(ram_we), .ram_adr_o(ram_adr), .ram_dat_o(ram_wdat), .ram_dat_i(ram_rdat),
      .busy_o(busy_o), .out_stb_o(out_stb_o), .out_data_o(out_data_o));

   dspengine_8to16 u_engine (
      .clk(clk), .rst_i(rst_i), .clear_i(clear_i), .convert_i(convert),
      .access_ok_i(access_ok), .access_len_i(access_len), .access_dat_i(ram_rdat),
      .access_we_o(eng_we), .access_done_o(access_done), .access_adr_o(eng_adr),
      .access_dat_o(eng_dat));

endmodule

/* src/dspengine_8to16.sv */
module dspengine_8to16
(
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       clear_i,
   input  logic                       convert_i,
   input  logic                       access_ok_i,
   input  logic [dsp_pkg::BUF_AW-1:0] access_len_i,
   input  logic [dsp_pkg::WORD_W-1:0] access_dat_i,
   output logic                       access_we_o,
   output logic                       access_done_o,
   output logic [dsp_pkg::BUF_AW-1:0] access_adr_o,
   output logic [dsp_pkg::WORD_W-1:0] access_dat_o
);

   localparam int AW = dsp_pkg::BUF_AW;

   dsp_pkg::dsp_state_e state_q;
   dsp_pkg::buf_word_u  in_w;
   dsp_pkg::buf_word_u  hdr_q;
   logic [31:0]         trailer_q;
   logic [15:0]         upper_q;
   logic [15:0]         upper;
   logic [3:0]          hdr_len;
   logic [3:0]          hdr_len_q;
   logic [AW-1:0]       read_adr_q;
   logic [AW-1:0]       write_adr_q;
   logic [AW-1:0]       data_in_len_q;
   logic [AW-1:0]       out_len;
   logic [AW-1:0]       first_adr;
   logic                odd_now;
   logic                odd_q;
   logic                trl_wait_q;
   logic                do_convert;

   assign in_w = access_dat_i[31:0];

   // VITA header words: header, stream id, class id (2), seconds, fraction (2)
   assign hdr_len = 4'd1
                  + {3'd0, in_w.hdr.has_sid}
                  + {2'd0, in_w.hdr.has_cid, 1'b0}
                  + {3'd0, |in_w.hdr.tsi}
                  + {2'd0, |in_w.hdr.tsf, 1'b0};

   assign do_convert = convert_i && (in_w.hdr.pkt_type == 3'd0) && in_w.hdr.has_trl;

   // trailer says the lower half of the last payload word is unused
   assign odd_now   = access_dat_i[20] & access_dat_i[8];
   assign out_len   = {data_in_len_q[AW-2:0], 1'b0} - {{(AW-1){1'b0}}, odd_now};
   assign first_adr = {{(AW-4){1'b0}}, hdr_len_q} + 1'b1;

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         state_q     <= dsp_pkg::IDLE;
         read_adr_q  <= AW'(1);
         write_adr_q <= AW'(1);
         odd_q       <= 1'b0;
         trl_wait_q  <= 1'b0;
      end
      else
      begin
         case (state_q)
            dsp_pkg::IDLE:
            begin
               // word 0 is the transport header, start at the VITA header
               read_adr_q  <= AW'(1);
               write_adr_q <= AW'(1);
               if (access_ok_i)
               begin
                  state_q <= dsp_pkg::PARSE_HEADER;
               end
            end
            dsp_pkg::PARSE_HEADER:
            begin
               trl_wait_q <= 1'b0;
               if (do_convert)
               begin
                  read_adr_q <= access_len_i - 1'b1;
                  state_q    <= dsp_pkg::READ_TRAILER;
               end
               else
               begin
                  state_q <= dsp_pkg::WRITE_HEADER;
               end
            end
            dsp_pkg::READ_TRAILER:
            begin
               // first cycle presents the address, second sees the trailer
               trl_wait_q <= 1'b1;
               if (trl_wait_q)
               begin
                  odd_q       <= odd_now;
                  write_adr_q <= AW'(hdr_len_q) + out_len + 1'b1;
                  state_q     <= dsp_pkg::WRITE_TRAILER;
               end
            end
            dsp_pkg::WRITE_TRAILER:
            begin
               write_adr_q <= write_adr_q - 1'b1;
               read_adr_q  <= read_adr_q - 1'b1;
               state_q     <= dsp_pkg::READ;
            end
            dsp_pkg::READ:
            begin
               read_adr_q <= read_adr_q - 1'b1;
               state_q    <= odd_q ? dsp_pkg::WRITE_0 : dsp_pkg::WRITE_1;
            end
            dsp_pkg::WRITE_1:
            begin
               write_adr_q <= write_adr_q - 1'b1;
               state_q     <= dsp_pkg::WRITE_0;
            end
            dsp_pkg::WRITE_0:
            begin
               write_adr_q <= write_adr_q - 1'b1;
               odd_q       <= 1'b0;
               if (write_adr_q == first_adr)
                  state_q <= dsp_pkg::WRITE_HEADER;
               else
                  state_q <= dsp_pkg::READ;
            end
            dsp_pkg::WRITE_HEADER:
            begin
               state_q <= dsp_pkg::DONE;
            end
            default:
            begin
               state_q <= dsp_pkg::IDLE;
            end
         endcase
      end
   end

   // header, trailer and sample holding registers
   always_ff @(posedge clk)
   begin
      if (state_q == dsp_pkg::PARSE_HEADER)
      begin
         hdr_q           <= in_w;
         hdr_q.hdr.length <= {{(16-AW){1'b0}}, access_len_i - 1'b1};
         hdr_len_q       <= hdr_len;
         data_in_len_q   <= access_len_i - AW'(hdr_len) - AW'(2);
      end
      if ((state_q == dsp_pkg::READ_TRAILER) && trl_wait_q)
      begin
         trailer_q <= access_dat_i[31:0];
      end
      // length is the address of the new trailer
      if (state_q == dsp_pkg::WRITE_TRAILER)
      begin
         hdr_q.hdr.length <= {{(16-AW){1'b0}}, write_adr_q};
      end
      if (state_q == dsp_pkg::WRITE_1)
      begin
         upper_q <= {in_w.smp.i0, in_w.smp.q0};
      end
   end

   // odd word goes straight from READ to WRITE_0, its data is still on the bus
   assign upper = odd_q ? {in_w.smp.i0, in_w.smp.q0} : upper_q;

   always_comb
   begin
      access_dat_o = '0;
      case (state_q)
         dsp_pkg::WRITE_HEADER:
            access_dat_o[31:0] = hdr_q;
         dsp_pkg::WRITE_TRAILER:
         begin
            access_dat_o[31:0]              = trailer_q;
            access_dat_o[dsp_pkg::FLAG_EOF] = 1'b1;
         end
         dsp_pkg::WRITE_1:
            access_dat_o[31:0] = {in_w.smp.i1, 8'h00, in_w.smp.q1, 8'h00};
         dsp_pkg::WRITE_0:
            access_dat_o[31:0] = {upper[15:8], 8'h00, upper[7:0], 8'h00};
         default:
            access_dat_o = '0;
      endcase
   end

   assign access_we_o = state_q inside {dsp_pkg::WRITE_HEADER, dsp_pkg::WRITE_TRAILER,
                                        dsp_pkg::WRITE_1, dsp_pkg::WRITE_0};
   assign access_done_o = (state_q == dsp_pkg::DONE);
   assign access_adr_o  = (state_q == dsp_pkg::WRITE_HEADER) ? AW'(1) :
                          access_we_o ? write_adr_q : read_adr_q;

   // the transport header at word 0 is never overwritten
   a_no_write_word0: assert property (@(posedge clk) disable iff (rst_i)
      access_we_o |-> (access_adr_o != '0))
      else $error("engine wrote the transport header word");

endmodule

/* src/pkt_buffer_ctrl.sv */
module pkt_buffer_ctrl
(
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       clear_i,

   input  logic                       in_stb_i,
   input  logic [dsp_pkg::WORD_W-1:0] in_data_i,

   input  logic                       eng_we_i,
   input  logic [dsp_pkg::BUF_AW-1:0] eng_adr_i,
   input  logic [dsp_pkg::WORD_W-1:0] eng_dat_i,
   input  logic                       access_done_i,
   output logic                       access_ok_o,
   output logic [dsp_pkg::BUF_AW-1:0] access_len_o,

   output logic                       ram_we_o,
   output logic [dsp_pkg::BUF_AW-1:0] ram_adr_o,
   output logic [dsp_pkg::WORD_W-1:0] ram_dat_o,
   input  logic [dsp_pkg::WORD_W-1:0] ram_dat_i,

   output logic                       busy_o,
   output logic                       out_stb_o,
   output logic [dsp_pkg::WORD_W-1:0] out_data_o
);

   typedef enum logic [1:0] {
      LOAD   = 2'd0,
      ENGINE = 2'd1,
      UNLOAD = 2'd2
   } phase_e;

   phase_e                     phase_q;
   logic [dsp_pkg::BUF_AW-1:0] wr_adr_q;
   logic [dsp_pkg::BUF_AW-1:0] rd_adr_q;
   logic [dsp_pkg::BUF_AW-1:0] load_adr;
   logic                       rd_pend_q;
   logic                       in_sof;
   logic                       in_eof;

   assign in_sof = in_data_i[dsp_pkg::FLAG_SOF];
   assign in_eof = in_data_i[dsp_pkg::FLAG_EOF];

   // a start flag always lands at word 0, which resyncs a broken load
   assign load_adr = in_sof ? '0 : wr_adr_q;

   always_ff @(posedge clk)
   begin
      if (rst_i || clear_i)
      begin
         phase_q   <= LOAD;
         wr_adr_q  <= '0;
         rd_adr_q  <= '0;
         rd_pend_q <= 1'b0;
      end
      else
      begin
         case (phase_q)
            LOAD:
            begin
               if (in_stb_i)
               begin
                  wr_adr_q <= load_adr + 1'b1;
                  if (in_eof)
                  begin
                     access_len_o <= load_adr + 1'b1;
                     phase_q      <= ENGINE;
                  end
               end
            end
            ENGINE:
            begin
               rd_adr_q  <= '0;
               rd_pend_q <= 1'b0;
               if (access_done_i)
               begin
                  phase_q <= UNLOAD;
               end
            end
            UNLOAD:
            begin
               // one read issued per cycle, data shows up on the next
               rd_adr_q  <= rd_adr_q + 1'b1;
               rd_pend_q <= 1'b1;
               if (rd_pend_q && ram_dat_i[dsp_pkg::FLAG_EOF])
               begin
                  phase_q   <= LOAD;
                  rd_pend_q <= 1'b0;
                  wr_adr_q  <= '0;
               end
            end
            default:
            begin
               phase_q <= LOAD;
            end
         endcase
      end
   end

   // port owner of the shared memory
   always_comb
   begin
      case (phase_q)
         ENGINE:
         begin
            ram_we_o  = eng_we_i;
            ram_adr_o = eng_adr_i;
            ram_dat_o = eng_dat_i;
         end
         UNLOAD:
         begin
            ram_we_o  = 1'b0;
            ram_adr_o = rd_adr_q;
            ram_dat_o = in_data_i;
         end
         default:
         begin
            ram_we_o  = in_stb_i;
            ram_adr_o = load_adr;
            ram_dat_o = in_data_i;
         end
      endcase
   end

   assign access_ok_o = (phase_q == ENGINE);
   assign busy_o      = (phase_q != LOAD);
   assign out_stb_o   = rd_pend_q;
   assign out_data_o  = ram_dat_i;

   a_eng_we_owned: assert property (@(posedge clk) disable iff (rst_i)
      eng_we_i |-> access_ok_o)
      else $error("engine wrote memory without access_ok");

   a_no_out_in_load: assert property (@(posedge clk) disable iff (rst_i)
      (phase_q == LOAD) |-> !out_stb_o)
      else $error("output strobe during load");

endmodule

/* src/pkt_buffer_ram.sv */
module pkt_buffer_ram
(
   input  logic                       clk,
   input  logic                       we_i,
   input  logic [dsp_pkg::BUF_AW-1:0] adr_i,
   input  logic [dsp_pkg::WORD_W-1:0] dat_i,
   output logic [dsp_pkg::WORD_W-1:0] dat_o
);

   localparam int DEPTH = 2 ** dsp_pkg::BUF_AW;

   logic [dsp_pkg::WORD_W-1:0] mem [DEPTH];

   always_ff @(posedge clk)
   begin
      if (we_i)
      begin
         mem[adr_i] <= dat_i;
      end
   end

   // registered read, old contents on a write to the same address
   always_ff @(posedge clk)
   begin
      dat_o <= mem[adr_i];
   end

endmodule

/* src/setting_reg.sv */
module setting_reg
#(
   parameter logic [7:0] ADDR  = dsp_pkg::CONV_ADDR,
   parameter int         WIDTH = 32
)
(
   input  logic             clk,
   input  logic             rst_i,
   input  logic             strobe_i,
   input  logic [7:0]       addr_i,
   input  logic [31:0]      data_i,
   output logic [WIDTH-1:0] out_o
);

   // only a write to our own address changes the value
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         out_o <= '0;
      end
      else if (strobe_i && (addr_i == ADDR))
      begin
         out_o <= data_i[WIDTH-1:0];
      end
   end

endmodule

/* src/dsp_pkg.sv */
package dsp_pkg;

   // buffer sizing, 512 words of 36 bits
   localparam int BUF_AW = 9;
   localparam int WORD_W = 36;

   // flag bits above the 32 data bits
   localparam int FLAG_SOF = 32;
   localparam int FLAG_EOF = 33;

   // settings bus address of the 8-to-16 enable
   localparam logic [7:0] CONV_ADDR = 8'h18;

   typedef enum logic [3:0] {
      IDLE          = 4'd0,
      PARSE_HEADER  = 4'd1,
      READ_TRAILER  = 4'd2,
      WRITE_TRAILER = 4'd3,
      READ          = 4'd4,
      WRITE_1       = 4'd5,
      WRITE_0       = 4'd6,
      WRITE_HEADER  = 4'd7,
      DONE          = 4'd8
   } dsp_state_e;

   // the data part of a buffer word, seen as a VITA header or as two 8-bit samples
   typedef union packed {
      struct packed {
         logic [2:0]  pkt_type;   // zero is IF data
         logic        has_sid;
         logic        has_cid;
         logic        has_trl;
         logic [1:0]  rsvd;
         logic [1:0]  tsi;
         logic [1:0]  tsf;
         logic [3:0]  count;
         logic [15:0] length;
      } hdr;
      struct packed {
         logic [7:0] i0;
         logic [7:0] q0;
         logic [7:0] i1;
         logic [7:0] q1;
      } smp;
   } buf_word_u;

endpackage
